// File: Bender.yml
package:
  name: dlx_core

sources:
  - files:
      - dlx_isa_pkg.sv
      - dlx_dp_pkg.sv
      - dlx_control.sv
      - dlx_reg_file.sv
      - dlx_fetch.sv
      - dlx_execute.sv
      - dlx_writeback.sv
      - dlx_core.sv
  - target: test
    files:
      - dlx_tb_clock.sv
      - dlx_tb.sv

// File: dlx_control.sv
module dlx_control (
  input  dlx_dp_pkg::word_t     instruction,
  output dlx_dp_pkg::reg_addr_t rs1_addr,
  output dlx_dp_pkg::reg_addr_t rs2_addr,
  output dlx_dp_pkg::reg_addr_t wr_addr,
  output logic                  reg_wr,
  output logic                  imm_sel,
  output logic                  imm_zext,
  output logic                  branch_z,
  output logic                  branch_nz,
  output logic                  jmp,
  output logic                  jmp_reg,
  output logic                  store,
  output logic                  mem_wr,
  output logic                  load_sext,
  output dlx_dp_pkg::alu_op_e   alu_op,
  output dlx_dp_pkg::mem_size_e mem_size,
  output dlx_dp_pkg::wb_sel_e   wb_sel
);
  import dlx_isa_pkg::*;
  import dlx_dp_pkg::*;

  logic [5:0] opcode;
  logic [5:0] func;

  assign opcode = instruction[opcode_msb:opcode_lsb];
  assign func   = instruction[5:0];

  // source registers come straight from the fields
  assign rs1_addr = instruction[rs1_msb:rs1_lsb];
  assign rs2_addr = instruction[rs2_msb:rs2_lsb];

  always_comb begin
    // defaults describe a no-op
    wr_addr   = instruction[rs2_msb:rs2_lsb];
    reg_wr    = 1'b0;
    imm_sel   = 1'b0;
    imm_zext  = 1'b0;
    branch_z  = 1'b0;
    branch_nz = 1'b0;
    jmp       = 1'b0;
    jmp_reg   = 1'b0;
    store     = 1'b0;
    mem_wr    = 1'b0;
    load_sext = 1'b0;
    alu_op    = ALU_ADD;
    mem_size  = MEM_WORD;
    wb_sel    = WB_ALU;
    case (opcode)
      OP_SPECIAL: begin
        // r-type writes rd
        wr_addr = instruction[rd_msb:rd_lsb];
        reg_wr  = 1'b1;
        case (func)
          FN_ADD:  alu_op = ALU_ADD;
          FN_SUB:  alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_XOR:  alu_op = ALU_XOR;
          FN_SLL:  alu_op = ALU_SLL;
          FN_SRL:  alu_op = ALU_SRL;
          FN_SRA:  alu_op = ALU_SRA;
          FN_SLT:  alu_op = ALU_SLT;
          FN_SLTU: alu_op = ALU_SLTU;
          // unknown function code, nothing written
          default: reg_wr = 1'b0;
        endcase
      end
      OP_ADDI: begin
        imm_sel = 1'b1;
        reg_wr  = 1'b1;
      end
      OP_SLTI: begin
        imm_sel = 1'b1;
        reg_wr  = 1'b1;
        alu_op  = ALU_SLT;
      end
      // logical immediates are zero extended
      OP_ANDI, OP_ORI, OP_XORI: begin
        imm_sel  = 1'b1;
        imm_zext = 1'b1;
        reg_wr   = 1'b1;
        alu_op   = (opcode == OP_ANDI) ? ALU_AND :
                   (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
      end
      OP_LHI: begin
        reg_wr = 1'b1;
        wb_sel = WB_UPPER;
      end
      OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
        // address is rs1 plus signed offset
        imm_sel   = 1'b1;
        reg_wr    = 1'b1;
        wb_sel    = WB_MEM;
        load_sext = (opcode == OP_LB) || (opcode == OP_LH);
        mem_size  = (opcode == OP_LB || opcode == OP_LBU) ? MEM_BYTE :
                    (opcode == OP_LH || opcode == OP_LHU) ? MEM_HALF : MEM_WORD;
      end
      OP_SB, OP_SH, OP_SW: begin
        imm_sel  = 1'b1;
        store    = 1'b1;
        mem_wr   = 1'b1;
        mem_size = (opcode == OP_SB) ? MEM_BYTE :
                   (opcode == OP_SH) ? MEM_HALF : MEM_WORD;
      end
      OP_BEQZ: branch_z  = 1'b1;
      OP_BNEZ: branch_nz = 1'b1;
      OP_J:    jmp       = 1'b1;
      OP_JR:   jmp_reg   = 1'b1;
      OP_JAL, OP_JALR: begin
        // link to r31 with pc+4
        jmp     = (opcode == OP_JAL);
        jmp_reg = (opcode == OP_JALR);
        reg_wr  = 1'b1;
        wr_addr = link_reg;
        wb_sel  = WB_LINK;
      end
      default: ;
    endcase
  end

endmodule

// File: dlx_core.sv
module dlx_core #(
  parameter dlx_dp_pkg::word_t reset_pc = '0
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  dlx_dp_pkg::word_t     instruction,
  input  dlx_dp_pkg::word_t     mem_read_data,
  output dlx_dp_pkg::word_t     pc,
  output dlx_dp_pkg::word_t     mem_addr,
  output dlx_dp_pkg::word_t     mem_write_data,
  output logic                  mem_wr,
  output dlx_dp_pkg::mem_size_e mem_size
);
  import dlx_dp_pkg::*;

  // decode outputs
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t wr_addr;
  logic      reg_wr;
  logic      imm_sel;
  logic      imm_zext;
  logic      branch_z;
  logic      branch_nz;
  logic      jmp;
  logic      jmp_reg;
  logic      store;
  logic      dec_mem_wr;
  logic      load_sext;
  alu_op_e   alu_op;
  wb_sel_e   wb_sel;

  // datapath
  word_t rs1_data;
  word_t rs2_data;
  word_t wr_data;
  word_t pc_plus4;
  logic  branch_taken;

  dlx_control i_control (
    .instruction (instruction),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .wr_addr     (wr_addr),
    .reg_wr      (reg_wr),
    .imm_sel     (imm_sel),
    .imm_zext    (imm_zext),
    .branch_z    (branch_z),
    .branch_nz   (branch_nz),
    .jmp         (jmp),
    .jmp_reg     (jmp_reg),
    .store       (store),
    .mem_wr      (dec_mem_wr),
    .load_sext   (load_sext),
    .alu_op      (alu_op),
    .mem_size    (mem_size),
    .wb_sel      (wb_sel)
  );

  // no write strobe reaches the bus while in reset
  assign mem_wr = dec_mem_wr & arst_n;

  dlx_reg_file i_reg_file (
    .clk      (clk),
    .arst_n   (arst_n),
    .reg_wr   (reg_wr),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  dlx_fetch #(
    .reset_pc (reset_pc)
  ) i_fetch (
    .clk          (clk),
    .arst_n       (arst_n),
    .branch_taken (branch_taken),
    .jmp          (jmp),
    .jmp_reg      (jmp_reg),
    .instruction  (instruction),
    .rs1_data     (rs1_data),
    .pc           (pc),
    .pc_plus4     (pc_plus4)
  );

  // alu result doubles as the data address
  dlx_execute i_execute (
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .instruction    (instruction),
    .alu_op         (alu_op),
    .imm_sel        (imm_sel),
    .imm_zext       (imm_zext),
    .branch_z       (branch_z),
    .branch_nz      (branch_nz),
    .store          (store),
    .mem_size       (mem_size),
    .alu_result     (mem_addr),
    .mem_write_data (mem_write_data),
    .branch_taken   (branch_taken)
  );

  dlx_writeback i_writeback (
    .alu_result    (mem_addr),
    .mem_read_data (mem_read_data),
    .pc_plus4      (pc_plus4),
    .instruction   (instruction),
    .wb_sel        (wb_sel),
    .mem_size      (mem_size),
    .load_sext     (load_sext),
    .wr_data       (wr_data)
  );

endmodule

// File: dlx_dp_pkg.sv
package dlx_dp_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // alu operations, shifts take the low 5 bits of b
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B
  } alu_op_e;

  // source of the register file write data
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_LINK,
    WB_UPPER
  } wb_sel_e;

  // access width of a load or store
  typedef enum logic [1:0] {
    MEM_BYTE,
    MEM_HALF,
    MEM_WORD
  } mem_size_e;

endpackage

// File: dlx_execute.sv
module dlx_execute (
  input  dlx_dp_pkg::word_t     rs1_data,
  input  dlx_dp_pkg::word_t     rs2_data,
  input  dlx_dp_pkg::word_t     instruction,
  input  dlx_dp_pkg::alu_op_e   alu_op,
  input  logic                  imm_sel,
  input  logic                  imm_zext,
  input  logic                  branch_z,
  input  logic                  branch_nz,
  input  logic                  store,
  input  dlx_dp_pkg::mem_size_e mem_size,
  output dlx_dp_pkg::word_t     alu_result,
  output dlx_dp_pkg::word_t     mem_write_data,
  output logic                  branch_taken
);
  import dlx_isa_pkg::*;
  import dlx_dp_pkg::*;

  logic [15:0] imm16;
  word_t       imm_ext;
  word_t       operand_b;
  logic [4:0]  shamt;
  logic        rs1_zero;
  word_t       store_data;

  assign imm16 = instruction[imm16_msb:imm16_lsb];

  // logical immediates zero extend, everything else sign extends
  assign imm_ext   = imm_zext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
  assign operand_b = imm_sel ? imm_ext : rs2_data;
  assign shamt     = operand_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_result = rs1_data + operand_b;
      ALU_SUB:    alu_result = rs1_data - operand_b;
      ALU_AND:    alu_result = rs1_data & operand_b;
      ALU_OR:     alu_result = rs1_data | operand_b;
      ALU_XOR:    alu_result = rs1_data ^ operand_b;
      ALU_SLL:    alu_result = rs1_data << shamt;
      ALU_SRL:    alu_result = rs1_data >> shamt;
      // arithmetic shift keeps the sign
      ALU_SRA:    alu_result = word_t'($signed(rs1_data) >>> shamt);
      ALU_SLT:    alu_result = {31'b0, $signed(rs1_data) < $signed(operand_b)};
      ALU_SLTU:   alu_result = {31'b0, rs1_data < operand_b};
      ALU_PASS_B: alu_result = operand_b;
      default:    alu_result = rs1_data + operand_b;
    endcase
  end

  // branch condition tests rs1 only
  assign rs1_zero     = (rs1_data == '0);
  assign branch_taken = (branch_z && rs1_zero) || (branch_nz && !rs1_zero);

  // byte and half repeated over all lanes, memory picks the lane
  always_comb begin
    case (mem_size)
      MEM_BYTE: store_data = {4{rs2_data[7:0]}};
      MEM_HALF: store_data = {2{rs2_data[15:0]}};
      default:  store_data = rs2_data;
    endcase
  end

  // bus idles at zero outside stores
  assign mem_write_data = store ? store_data : '0;

endmodule

// File: dlx_fetch.sv
module dlx_fetch #(
  parameter dlx_dp_pkg::word_t reset_pc = '0
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              branch_taken,
  input  logic              jmp,
  input  logic              jmp_reg,
  input  dlx_dp_pkg::word_t instruction,
  input  dlx_dp_pkg::word_t rs1_data,
  output dlx_dp_pkg::word_t pc,
  output dlx_dp_pkg::word_t pc_plus4
);
  import dlx_isa_pkg::*;
  import dlx_dp_pkg::*;

  word_t imm16_sext;
  word_t imm26_sext;
  word_t next_pc;

  assign pc_plus4 = pc + 32'd4;

  // offsets are relative to pc+4
  assign imm16_sext = {{16{instruction[imm16_msb]}}, instruction[imm16_msb:imm16_lsb]};
  assign imm26_sext = {{6{instruction[imm26_msb]}}, instruction[imm26_msb:imm26_lsb]};

  // register jump wins, then j/jal, then branch
  always_comb begin
    if (jmp_reg) begin
      next_pc = rs1_data;
    end else if (jmp) begin
      next_pc = pc_plus4 + imm26_sext;
    end else if (branch_taken) begin
      next_pc = pc_plus4 + imm16_sext;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

// File: dlx_isa_pkg.sv
package dlx_isa_pkg;

  // primary opcode, bits 31:26
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQZ    = 6'h04,
    OP_BNEZ    = 6'h05,
    OP_ADDI    = 6'h08,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_XORI    = 6'h0e,
    OP_LHI     = 6'h0f,
    OP_JR      = 6'h12,
    OP_JALR    = 6'h13,
    OP_SLTI    = 6'h1a,
    OP_LB      = 6'h20,
    OP_LH      = 6'h21,
    OP_LW      = 6'h23,
    OP_LBU     = 6'h24,
    OP_LHU     = 6'h25,
    OP_SB      = 6'h28,
    OP_SH      = 6'h29,
    OP_SW      = 6'h2b
  } opcode_e;

  // r-type function code, bits 5:0
  typedef enum logic [5:0] {
    FN_SLL  = 6'h04,
    FN_SRL  = 6'h06,
    FN_SRA  = 6'h07,
    FN_ADD  = 6'h20,
    FN_SUB  = 6'h22,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a,
    FN_SLTU = 6'h2b
  } func_e;

  // field positions, msb and lsb
  localparam int unsigned opcode_msb = 31;
  localparam int unsigned opcode_lsb = 26;
  localparam int unsigned rs1_msb    = 25;
  localparam int unsigned rs1_lsb    = 21;
  localparam int unsigned rs2_msb    = 20;
  localparam int unsigned rs2_lsb    = 16;
  localparam int unsigned rd_msb     = 15;
  localparam int unsigned rd_lsb     = 11;
  localparam int unsigned imm16_msb  = 15;
  localparam int unsigned imm16_lsb  = 0;
  localparam int unsigned imm26_msb  = 25;
  localparam int unsigned imm26_lsb  = 0;

  // jal and jalr write their return address here
  localparam logic [4:0] link_reg = 5'd31;

endpackage

// File: dlx_reg_file.sv
module dlx_reg_file (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  reg_wr,
  input  dlx_dp_pkg::reg_addr_t rs1_addr,
  input  dlx_dp_pkg::reg_addr_t rs2_addr,
  input  dlx_dp_pkg::reg_addr_t wr_addr,
  input  dlx_dp_pkg::word_t     wr_data,
  output dlx_dp_pkg::word_t     rs1_data,
  output dlx_dp_pkg::word_t     rs2_data
);
  import dlx_dp_pkg::*;

  // r1..r31, r0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_wr && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // combinational reads
  // r0 reads zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: dlx_tb.sv
module dlx_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import dlx_isa_pkg::*;
  import dlx_dp_pkg::*;

  localparam word_t reset_pc   = 32'h0000_0100;
  localparam int    max_cycles = 2000;

  logic      clk;
  logic      arst_n;
  word_t     instruction;
  word_t     mem_read_data;
  word_t     pc;
  word_t     mem_addr;
  word_t     mem_write_data;
  logic      mem_wr;
  mem_size_e mem_size;

  // instruction memory, and data memory written by the dut
  word_t imem [0:1023];
  word_t dmem [0:255];

  // reference model state
  word_t m_regs [0:31];
  word_t m_mem  [0:255];
  word_t m_pc;

  // expected bus values for the instruction now presented
  word_t     exp_pc;
  word_t     exp_addr;
  word_t     exp_wdata;
  logic      exp_mem_wr;
  logic      exp_mem_op;
  mem_size_e exp_size;

  int    wp;
  int    res_off;
  word_t done_pc;

  dlx_tb_clock #(.period_ns(4), .reset_cycles(2)) i_clock (.clk(clk), .arst_n(arst_n));

  dlx_core #(.reset_pc(reset_pc)) i_dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .instruction    (instruction),
    .mem_read_data  (mem_read_data),
    .pc             (pc),
    .mem_addr       (mem_addr),
    .mem_write_data (mem_write_data),
    .mem_wr         (mem_wr),
    .mem_size       (mem_size)
  );

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  function automatic word_t fill_pattern(word_t addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic word_t sext16(logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic word_t r_format(func_e fn, logic [4:0] rs1, logic [4:0] rs2, logic [4:0] rd);
    return {OP_SPECIAL, rs1, rs2, rd, 5'd0, fn};
  endfunction

  // stores put the data register in the rs2 slot
  function automatic word_t i_format(opcode_e op, logic [4:0] rs1, logic [4:0] rs2,
                                     logic [15:0] imm);
    return {op, rs1, rs2, imm};
  endfunction

  function automatic word_t j_format(opcode_e op, word_t off);
    return {op, off[25:0]};
  endfunction

  task automatic emit(word_t w);
    imem[wp] = w;
    wp++;
  endtask

  // offset from the next instruction to word index target
  function automatic logic [15:0] rel_offset(int target);
    return 16'((target - (wp + 1)) * 4);
  endfunction

  task automatic load_const(logic [4:0] rd, word_t v);
    emit(i_format(OP_LHI, 5'd0, rd, v[31:16]));
    emit(i_format(OP_ORI, rd, rd, v[15:0]));
  endtask

  // results land in consecutive words from address 0
  task automatic store_result(logic [4:0] rs);
    emit(i_format(OP_SW, 5'd0, rs, 16'(res_off)));
    res_off += 4;
  endtask

  task automatic build_program();
    func_e       fns  [10];
    opcode_e     iops [5];
    logic [15:0] imm;
    int          mark;
    fns  = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLL, FN_SRL, FN_SRA, FN_SLT, FN_SLTU};
    iops = '{OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI};
    wp      = int'(reset_pc >> 2);
    res_off = 0;
    // a store sits at reset_pc while reset is held
    emit(i_format(OP_SW, 5'd0, 5'd0, 16'h03fc));
    // random operands, r3 forced negative
    load_const(5'd1, $urandom());
    load_const(5'd2, $urandom());
    load_const(5'd3, $urandom() | 32'h8000_0000);
    foreach (fns[i]) begin
      emit(r_format(fns[i], 5'd1, 5'd2, 5'd5));
      emit(r_format(fns[i], 5'd3, 5'd1, 5'd6));
      store_result(5'd5);
      store_result(5'd6);
    end
    // one immediate with bit 15 clear, one with it set
    foreach (iops[i]) begin
      imm = 16'($urandom());
      emit(i_format(iops[i], 5'd1, 5'd5, imm & 16'h7fff));
      emit(i_format(iops[i], 5'd3, 5'd6, imm | 16'h8000));
      store_result(5'd5);
      store_result(5'd6);
    end
    emit(i_format(OP_LHI, 5'd0, 5'd5, 16'($urandom())));
    store_result(5'd5);
    // r0 must stay zero
    emit(r_format(FN_ADD, 5'd1, 5'd2, 5'd0));
    emit(i_format(OP_ADDI, 5'd1, 5'd0, 16'h1234));
    store_result(5'd0);
    // lane tests around 0x300
    emit(i_format(OP_ADDI, 5'd0, 5'd20, 16'h0300));
    for (int k = 0; k < 4; k++) begin
      emit(i_format(OP_SB, 5'd20, k[0] ? 5'd3 : 5'd1, 16'(k)));
    end
    emit(i_format(OP_SH, 5'd20, 5'd3, 16'h0004));
    emit(i_format(OP_SH, 5'd20, 5'd1, 16'h0006));
    for (int k = 0; k < 4; k++) begin
      emit(i_format(OP_LB,  5'd20, 5'd5, 16'(k)));
      emit(i_format(OP_LBU, 5'd20, 5'd6, 16'(k)));
      emit(i_format(OP_LB,  5'd20, 5'd7, 16'(8 + k)));
      emit(i_format(OP_LH,  5'd20, 5'd8, 16'(4 + k)));
      emit(i_format(OP_LHU, 5'd20, 5'd9, 16'(12 + k)));
      for (int r = 5; r < 10; r++) begin
        store_result(5'(r));
      end
    end
    // negative offset reaches 0x200
    emit(i_format(OP_LW, 5'd20, 5'd5, 16'hff00));
    store_result(5'd5);
    // beqz taken forward, bnez and beqz not taken
    emit(i_format(OP_ADDI, 5'd0, 5'd8, 16'h0000));
    emit(i_format(OP_BEQZ, 5'd0, 5'd0, 16'h0004));
    emit(i_format(OP_ADDI, 5'd8, 5'd8, 16'h0001));
    emit(i_format(OP_BNEZ, 5'd0, 5'd0, 16'h0004));
    emit(i_format(OP_ADDI, 5'd8, 5'd8, 16'h0002));
    emit(i_format(OP_BEQZ, 5'd3, 5'd0, 16'h0004));
    emit(i_format(OP_ADDI, 5'd8, 5'd8, 16'h0004));
    // counted loop, bnez taken backward
    emit(i_format(OP_ADDI, 5'd0, 5'd9, 16'h0003));
    mark = wp;
    emit(i_format(OP_ADDI, 5'd9, 5'd9, 16'hffff));
    emit(i_format(OP_ADDI, 5'd8, 5'd8, 16'h0010));
    emit(i_format(OP_BNEZ, 5'd9, 5'd0, rel_offset(mark)));
    store_result(5'd8);
    store_result(5'd9);
    // each jump skips one addi to r10
    emit(j_format(OP_J, 32'd4));
    emit(i_format(OP_ADDI, 5'd0, 5'd10, 16'h0bad));
    emit(j_format(OP_JAL, 32'd4));
    emit(i_format(OP_ADDI, 5'd10, 5'd10, 16'h0001));
    store_result(5'd31);
    emit(i_format(OP_ADDI, 5'd0, 5'd11, 16'((wp + 3) * 4)));
    emit(i_format(OP_JR, 5'd11, 5'd0, 16'h0000));
    emit(i_format(OP_ADDI, 5'd10, 5'd10, 16'h0002));
    emit(i_format(OP_ADDI, 5'd0, 5'd11, 16'((wp + 3) * 4)));
    emit(i_format(OP_JALR, 5'd11, 5'd0, 16'h0000));
    emit(i_format(OP_ADDI, 5'd10, 5'd10, 16'h0004));
    store_result(5'd31);
    store_result(5'd10);
    // unknown opcode, then unknown function code into r12
    emit(32'hffff_ffff);
    emit({6'h00, 5'd1, 5'd2, 5'd12, 5'd0, 6'h3f});
    store_result(5'd12);
    // self loop marks the end
    done_pc = word_t'(wp) << 2;
    emit(j_format(OP_J, 32'hffff_fffc));
  endtask

  // one instruction of the reference model
  task automatic model_step(word_t ins);
    logic [5:0] op;
    logic [4:0] dst;
    word_t      a;
    word_t      b;
    word_t      addr;
    word_t      res;
    word_t      nxt;
    word_t      byte_w;
    word_t      half_w;
    logic       wr;
    op     = ins[31:26];
    a      = m_regs[ins[25:21]];
    b      = m_regs[ins[20:16]];
    dst    = ins[20:16];
    addr   = a + sext16(ins[15:0]);
    byte_w = m_mem[addr[9:2]] >> (8 * addr[1:0]);
    half_w = m_mem[addr[9:2]] >> (16 * addr[1]);
    nxt    = m_pc + 32'd4;
    res    = '0;
    wr     = 1'b1;
    case (op)
      OP_SPECIAL: begin
        dst = ins[15:11];
        case (ins[5:0])
          FN_ADD:  res = a + b;
          FN_SUB:  res = a - b;
          FN_AND:  res = a & b;
          FN_OR:   res = a | b;
          FN_XOR:  res = a ^ b;
          FN_SLL:  res = a << b[4:0];
          FN_SRL:  res = a >> b[4:0];
          FN_SRA:  res = $signed(a) >>> b[4:0];
          FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
          default: wr = 1'b0;
        endcase
      end
      OP_ADDI: res = a + sext16(ins[15:0]);
      OP_SLTI: res = ($signed(a) < $signed(sext16(ins[15:0]))) ? 32'd1 : 32'd0;
      OP_ANDI: res = a & {16'h0000, ins[15:0]};
      OP_ORI:  res = a | {16'h0000, ins[15:0]};
      OP_XORI: res = a ^ {16'h0000, ins[15:0]};
      OP_LHI:  res = {ins[15:0], 16'h0000};
      OP_LB:   res = {{24{byte_w[7]}}, byte_w[7:0]};
      OP_LBU:  res = {24'h000000, byte_w[7:0]};
      OP_LH:   res = {{16{half_w[15]}}, half_w[15:0]};
      OP_LHU:  res = {16'h0000, half_w[15:0]};
      OP_LW:   res = m_mem[addr[9:2]];
      OP_JAL, OP_JALR: begin
        res = m_pc + 32'd4;
        dst = 5'd31;
        nxt = (op == OP_JAL) ? m_pc + 32'd4 + {{6{ins[25]}}, ins[25:0]} : a;
      end
      default: begin
        wr = 1'b0;
        case (op)
          OP_SB:   m_mem[addr[9:2]][8 * addr[1:0] +: 8] = b[7:0];
          OP_SH:   m_mem[addr[9:2]][16 * addr[1] +: 16] = b[15:0];
          OP_SW:   m_mem[addr[9:2]] = b;
          OP_BEQZ: nxt = (a == '0) ? m_pc + 32'd4 + sext16(ins[15:0]) : nxt;
          OP_BNEZ: nxt = (a != '0) ? m_pc + 32'd4 + sext16(ins[15:0]) : nxt;
          OP_J:    nxt = m_pc + 32'd4 + {{6{ins[25]}}, ins[25:0]};
          OP_JR:   nxt = a;
          default: ;
        endcase
      end
    endcase
    if (wr && dst != 5'd0) begin
      m_regs[dst] = res;
    end
    m_pc = nxt;
  endtask

  // bus values the model predicts for the instruction at m_pc
  task automatic set_expected();
    word_t      ins;
    logic [5:0] op;
    word_t      src;
    ins        = imem[m_pc[11:2]];
    op         = ins[31:26];
    src        = m_regs[ins[20:16]];
    exp_pc     = m_pc;
    exp_addr   = m_regs[ins[25:21]] + sext16(ins[15:0]);
    exp_mem_wr = op inside {OP_SB, OP_SH, OP_SW};
    exp_mem_op = exp_mem_wr || (op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW});
    if (op inside {OP_SB, OP_LB, OP_LBU}) begin
      exp_size = MEM_BYTE;
    end else if (op inside {OP_SH, OP_LH, OP_LHU}) begin
      exp_size = MEM_HALF;
    end else begin
      exp_size = MEM_WORD;
    end
    // each lane carries the byte it would hold at that lane
    for (int k = 0; k < 4; k++) begin
      case (exp_size)
        MEM_BYTE: exp_wdata[8 * k +: 8] = src[7:0];
        MEM_HALF: exp_wdata[8 * k +: 8] = src[8 * (k % 2) +: 8];
        default:  exp_wdata[8 * k +: 8] = src[8 * k +: 8];
      endcase
    end
  endtask

  always @(negedge clk) begin
    set_expected();
    instruction   = imem[pc[11:2]];
    mem_read_data = dmem[exp_addr[9:2]];
  end

  // memory takes the dut store, model retires the same instruction
  always @(posedge clk) begin
    if (arst_n) begin
      if (mem_wr) begin
        case (mem_size)
          MEM_BYTE: dmem[mem_addr[9:2]][8 * mem_addr[1:0] +: 8] =
                      mem_write_data[8 * mem_addr[1:0] +: 8];
          MEM_HALF: dmem[mem_addr[9:2]][16 * mem_addr[1] +: 16] =
                      mem_write_data[16 * mem_addr[1] +: 16];
          default:  dmem[mem_addr[9:2]] = mem_write_data;
        endcase
      end
      model_step(imem[m_pc[11:2]]);
    end
  end

  reset_pc_check: assert property (@(posedge clk) !arst_n |-> pc == reset_pc)
    else stop_on_error($sformatf("ERROR pc in reset: got %08h expected %08h",
                                 $sampled(pc), reset_pc));
  reset_wr_check: assert property (@(posedge clk) !arst_n |-> !mem_wr)
    else stop_on_error($sformatf("ERROR mem_wr in reset: got %0h expected 0",
                                 $sampled(mem_wr)));
  pc_check: assert property (@(posedge clk) disable iff (!arst_n) pc == exp_pc)
    else stop_on_error($sformatf("ERROR pc: got %08h expected %08h",
                                 $sampled(pc), $sampled(exp_pc)));
  wr_check: assert property (@(posedge clk) disable iff (!arst_n) mem_wr == exp_mem_wr)
    else stop_on_error($sformatf("ERROR mem_wr: got %0h expected %0h",
                                 $sampled(mem_wr), $sampled(exp_mem_wr)));
  addr_check: assert property (@(posedge clk) disable iff (!arst_n)
                               exp_mem_op |-> mem_addr == exp_addr)
    else stop_on_error($sformatf("ERROR mem_addr: got %08h expected %08h",
                                 $sampled(mem_addr), $sampled(exp_addr)));
  size_check: assert property (@(posedge clk) disable iff (!arst_n)
                               exp_mem_op |-> mem_size == exp_size)
    else stop_on_error($sformatf("ERROR mem_size: got %0h expected %0h",
                                 $sampled(mem_size), $sampled(exp_size)));
  wdata_check: assert property (@(posedge clk) disable iff (!arst_n)
                                exp_mem_wr |-> mem_write_data == exp_wdata)
    else stop_on_error($sformatf("ERROR mem_write_data: got %08h expected %08h",
                                 $sampled(mem_write_data), $sampled(exp_wdata)));

  initial begin
    int cycles;
    instruction   = '0;
    mem_read_data = '0;
    void'($urandom(32'hd19b50cb));
    for (int i = 0; i < 1024; i++) begin
      imem[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i]  = fill_pattern(word_t'(i) << 2);
      m_mem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_pc = reset_pc;
    build_program();

    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > 10) begin
        stop_on_error("reset was never released");
      end
    end while (arst_n !== 1'b1);

    cycles = 0;
    while (pc !== done_pc) begin
      @(negedge clk);
      cycles++;
      if (cycles > max_cycles) begin
        stop_on_error("timeout waiting for the pc to reach the final loop");
      end
    end
    // a few turns of the self loop
    repeat (4) @(negedge clk);

    for (int i = 0; i < 256; i++) begin
      assert (dmem[i] == m_mem[i])
        else stop_on_error($sformatf("ERROR dmem[%02h]: got %08h expected %08h",
                                     i, dmem[i], m_mem[i]));
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: dlx_tb_clock.sv
module dlx_tb_clock #(
  parameter int period_ns    = 4,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic arst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // start high so arst_n sees a real falling edge
  initial begin
    arst_n = 1'b1;
    #1 arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    // release on a falling edge, away from the rising edge
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

// File: dlx_writeback.sv
module dlx_writeback (
  input  dlx_dp_pkg::word_t     alu_result,
  input  dlx_dp_pkg::word_t     mem_read_data,
  input  dlx_dp_pkg::word_t     pc_plus4,
  input  dlx_dp_pkg::word_t     instruction,
  input  dlx_dp_pkg::wb_sel_e   wb_sel,
  input  dlx_dp_pkg::mem_size_e mem_size,
  input  logic                  load_sext,
  output dlx_dp_pkg::word_t     wr_data
);
  import dlx_dp_pkg::*;

  logic [7:0]  load_byte;
  logic [15:0] load_half;
  word_t       load_value;

  // little-endian lanes by address low bits
  always_comb begin
    case (alu_result[1:0])
      2'd0:    load_byte = mem_read_data[7:0];
      2'd1:    load_byte = mem_read_data[15:8];
      2'd2:    load_byte = mem_read_data[23:16];
      default: load_byte = mem_read_data[31:24];
    endcase
  end

  // bit 0 is ignored for halfwords
  assign load_half = alu_result[1] ? mem_read_data[31:16] : mem_read_data[15:0];

  always_comb begin
    case (mem_size)
      MEM_BYTE: load_value = {{24{load_sext & load_byte[7]}}, load_byte};
      MEM_HALF: load_value = {{16{load_sext & load_half[15]}}, load_half};
      default:  load_value = mem_read_data;
    endcase
  end

  always_comb begin
    case (wb_sel)
      WB_MEM:   wr_data = load_value;
      WB_LINK:  wr_data = pc_plus4;
      // lhi puts imm16 in the upper half
      WB_UPPER: wr_data = {instruction[15:0], 16'h0000};
      default:  wr_data = alu_result;
    endcase
  end

endmodule

// File: verilog.f
dlx_isa_pkg.sv
dlx_dp_pkg.sv
dlx_control.sv
dlx_reg_file.sv
dlx_fetch.sv
dlx_execute.sv
dlx_writeback.sv
dlx_core.sv
dlx_tb_clock.sv
dlx_tb.sv
